/* include/a2_clk_defines.svh */
`ifndef A2_CLK_DEFINES_SVH
`define A2_CLK_DEFINES_SVH

// Synchronizer flops on each raw bus clock input
`define A2_SYNC_STAGES 2

// Equal samples needed before the filtered level follows the input
`define A2_DENOISE_CYCLES 3

// Per-window rising edge count width
`define A2_EDGE_COUNT_W 16

// Window timer width, wide enough for the default window
`define A2_WINDOW_W 26

`define A2_WINDOW_CYCLES_DEFAULT 10_000_000  // About half a second of clk_logic_w

`define A2_POR_CYCLES 100  // Device reset hold after arst release

`endif

/* rtl/a2_clk_pkg.sv */
`default_nettype none

`include "a2_clk_defines.svh"

package a2_clk_pkg;

    // Rising edges seen in one window
    typedef logic [`A2_EDGE_COUNT_W-1:0] edge_count_t;

    typedef logic [`A2_WINDOW_W-1:0] window_count_t;  // Window timer value

    // Run length of samples that differ from the filtered level
    typedef logic [1:0] denoise_count_t;

    typedef logic [6:0] por_count_t;  // Counts up to A2_POR_CYCLES

    // Power-on reset sequence
    typedef enum logic [1:0] {
        POR_HOLD,  // Counting out the hold time
        POR_SYNC,  // Two-stage release
        POR_RUN    // Device running
    } por_state_t;

endpackage

`default_nettype wire

/* rtl/clk_track_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One Apple II bus clock after synchronization and filtering
interface clk_track_if
    import a2_clk_pkg::*;
();

    logic        level;       // Filtered clock level
    logic        rise;        // Single-cycle rising edge strobe
    logic        fall;        // Single-cycle falling edge strobe
    logic        window_end;  // Window boundary from the reporter
    edge_count_t count;       // Rising edges in the current window

    modport tracker (
        output level,
        output rise,
        output fall,
        output count,
        input  window_end
    );

    modport reporter (
        input  level,
        input  rise,
        input  fall,
        input  count,
        output window_end
    );

endinterface

`default_nettype wire

/* rtl/bus_clock_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "a2_clk_defines.svh"

module bus_clock_tracker
    import a2_clk_pkg::*;
(
    input  logic         clk_logic_w,
    input  logic         arst,
    input  logic         dev_rst_i,
    input  logic         bus_clk_i,  // Raw Apple II clock
    clk_track_if.tracker trk
);

    logic [`A2_SYNC_STAGES-1:0] sync_r;
    logic                       sampled_w;
    denoise_count_t             run_cnt_r;
    logic                       level_r;
    logic                       rise_r;
    logic                       fall_r;
    edge_count_t                edge_cnt_r;

    // Bring the bus clock into the logic domain
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            sync_r <= '0;
        end else begin
            sync_r <= {sync_r[`A2_SYNC_STAGES-2:0], bus_clk_i};
        end
    end

    assign sampled_w = sync_r[`A2_SYNC_STAGES-1];

    // Level follows the input only after a full run of equal samples,
    // so short glitches never produce an edge
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            run_cnt_r <= '0;
            level_r   <= 1'b0;
            rise_r    <= 1'b0;
            fall_r    <= 1'b0;
        end else begin
            rise_r <= 1'b0;
            fall_r <= 1'b0;
            if (sampled_w == level_r) begin
                run_cnt_r <= '0;  // Glitch ended, start over
            end else if (run_cnt_r == denoise_count_t'(`A2_DENOISE_CYCLES - 1)) begin
                run_cnt_r <= '0;
                level_r   <= sampled_w;
                rise_r    <= sampled_w;   // Strobe lines up with the level change
                fall_r    <= ~sampled_w;
            end else begin
                run_cnt_r <= run_cnt_r + 1'b1;
            end
        end
    end

    // Rising edge count per window
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            edge_cnt_r <= '0;
        end else if (dev_rst_i) begin
            edge_cnt_r <= '0;
        end else if (trk.window_end) begin
            edge_cnt_r <= edge_count_t'(rise_r);  // Edge on the boundary opens the new window
        end else if (rise_r && (edge_cnt_r != '1)) begin
            edge_cnt_r <= edge_cnt_r + 1'b1;      // Saturates at full scale
        end
    end

    assign trk.level = level_r;
    assign trk.rise  = rise_r;
    assign trk.fall  = fall_r;
    assign trk.count = edge_cnt_r;  // Ending window's total while window_end is high

endmodule

`default_nettype wire

/* rtl/activity_reporter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "a2_clk_defines.svh"

module activity_reporter
    import a2_clk_pkg::*;
#(
    parameter int WINDOW_CYCLES = `A2_WINDOW_CYCLES_DEFAULT
) (
    input  logic          clk_logic_w,
    input  logic          arst,
    input  logic          dev_rst_i,
    clk_track_if.reporter phi1_trk,
    clk_track_if.reporter q3_trk,
    output logic          report_valid_o,
    input  logic          report_ready_i,
    output edge_count_t   report_phi1_o,
    output edge_count_t   report_q3_o,
    output logic          report_overrun_o,
    output logic [1:0]    led_o
);

    window_count_t win_cnt_r;
    logic          window_end_r;
    logic          heartbeat_r;
    logic          phi1_active_r;
    logic          valid_r;
    logic          overrun_r;
    edge_count_t   phi1_cnt_r;
    edge_count_t   q3_cnt_r;
    logic          pending_w;
    logic          take_w;

    assign take_w    = valid_r & report_ready_i;
    assign pending_w = valid_r & ~report_ready_i;  // Report still waiting after this clock

    // Window timer, shared by both trackers
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            win_cnt_r    <= '0;
            window_end_r <= 1'b0;
        end else if (dev_rst_i) begin
            win_cnt_r    <= '0;
            window_end_r <= 1'b0;
        end else if (win_cnt_r == window_count_t'(WINDOW_CYCLES - 1)) begin
            win_cnt_r    <= '0;
            window_end_r <= 1'b1;
        end else begin
            win_cnt_r    <= win_cnt_r + 1'b1;
            window_end_r <= 1'b0;
        end
    end

    assign phi1_trk.window_end = window_end_r;
    assign q3_trk.window_end   = window_end_r;

    // Heartbeat and Phi1 activity
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            heartbeat_r   <= 1'b0;
            phi1_active_r <= 1'b0;
        end else if (window_end_r) begin
            heartbeat_r   <= ~heartbeat_r;
            phi1_active_r <= (phi1_trk.count != '0);
        end
    end

    assign led_o = {phi1_active_r, heartbeat_r};

    // Report handshake
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            valid_r   <= 1'b0;
            overrun_r <= 1'b0;
        end else if (dev_rst_i) begin
            valid_r   <= 1'b0;
            overrun_r <= 1'b0;
        end else if (window_end_r) begin
            if (pending_w) begin
                overrun_r <= 1'b1;  // Window dropped, flag rides on the held report
            end else begin
                valid_r   <= 1'b1;
                overrun_r <= 1'b0;
            end
        end else if (take_w) begin
            valid_r   <= 1'b0;
            overrun_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (window_end_r && !pending_w) begin
            phi1_cnt_r <= phi1_trk.count;
            q3_cnt_r   <= q3_trk.count;
        end
    end

    assign report_valid_o   = valid_r;
    assign report_phi1_o    = phi1_cnt_r;
    assign report_q3_o      = q3_cnt_r;
    assign report_overrun_o = overrun_r;

endmodule

`default_nettype wire

/* rtl/power_on_reset.sv */
`timescale 1ns/1ps
`default_nettype none

`include "a2_clk_defines.svh"

module power_on_reset
    import a2_clk_pkg::*;
(
    input  logic clk_logic_w,
    input  logic arst,
    input  logic a2_reset_n_i,     // Apple II reset line, asynchronous
    output logic dev_rst_o,
    output logic system_reset_n_o
);

    por_state_t                 state_r;
    por_count_t                 por_cnt_r;
    logic [1:0]                 release_r;
    logic [`A2_SYNC_STAGES-1:0] a2_rst_sync_r;
    logic                       system_reset_n_r;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            state_r   <= POR_HOLD;
            por_cnt_r <= '0;
            release_r <= '0;
        end else begin
            case (state_r)
                POR_HOLD: begin
                    if (por_cnt_r == por_count_t'(`A2_POR_CYCLES - 1)) begin
                        state_r <= POR_SYNC;
                    end else begin
                        por_cnt_r <= por_cnt_r + 1'b1;
                    end
                end
                POR_SYNC: begin
                    release_r <= {release_r[0], 1'b1};
                    if (release_r[0]) begin
                        state_r <= POR_RUN;  // Second stage set on this clock
                    end
                end
                default: ;  // POR_RUN holds
            endcase
        end
    end

    assign dev_rst_o = ~release_r[1];

    // Apple II reset into the logic domain
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            a2_rst_sync_r    <= '0;
            system_reset_n_r <= 1'b0;
        end else begin
            a2_rst_sync_r    <= {a2_rst_sync_r[`A2_SYNC_STAGES-2:0], a2_reset_n_i};
            system_reset_n_r <= release_r[1] & a2_rst_sync_r[`A2_SYNC_STAGES-1];
        end
    end

    assign system_reset_n_o = system_reset_n_r;

endmodule

`default_nettype wire

/* rtl/a2_clock_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "a2_clk_defines.svh"

module a2_clock_monitor
    import a2_clk_pkg::*;
#(
    parameter int WINDOW_CYCLES = `A2_WINDOW_CYCLES_DEFAULT
) (
    input  logic        clk_logic_w,
    input  logic        arst,
    input  logic        a2_phi1_i,
    input  logic        a2_q3_i,
    input  logic        a2_reset_n_i,
    input  logic        report_ready_i,
    output logic        report_valid_o,
    output edge_count_t report_phi1_o,
    output edge_count_t report_q3_o,
    output logic        report_overrun_o,
    output logic [1:0]  led_o,             // [0] heartbeat, [1] Phi1 running
    output logic        system_reset_n_o
);

    wire dev_rst_w;

    clk_track_if phi1_trk ();
    clk_track_if q3_trk ();

    // Reset generation
    power_on_reset u_power_on_reset (
        .clk_logic_w      (clk_logic_w),
        .arst             (arst),
        .a2_reset_n_i     (a2_reset_n_i),
        .dev_rst_o        (dev_rst_w),
        .system_reset_n_o (system_reset_n_o)
    );

    bus_clock_tracker u_phi1_tracker (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .dev_rst_i   (dev_rst_w),
        .bus_clk_i   (a2_phi1_i),
        .trk         (phi1_trk.tracker)
    );

    bus_clock_tracker u_q3_tracker (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .dev_rst_i   (dev_rst_w),
        .bus_clk_i   (a2_q3_i),
        .trk         (q3_trk.tracker)
    );

    // Window timing, LEDs and rate report
    activity_reporter #(
        .WINDOW_CYCLES (WINDOW_CYCLES)
    ) u_activity_reporter (
        .clk_logic_w      (clk_logic_w),
        .arst             (arst),
        .dev_rst_i        (dev_rst_w),
        .phi1_trk         (phi1_trk.reporter),
        .q3_trk           (q3_trk.reporter),
        .report_valid_o   (report_valid_o),
        .report_ready_i   (report_ready_i),
        .report_phi1_o    (report_phi1_o),
        .report_q3_o      (report_q3_o),
        .report_overrun_o (report_overrun_o),
        .led_o            (led_o)
    );

endmodule

`default_nettype wire

/* test/tb_a2_clock_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "a2_clk_defines.svh"

module tb_a2_clock_monitor
    import a2_clk_pkg::*;
();

    localparam int WINDOW     = 1000;
    localparam int WAIT_LIMIT = 3 * WINDOW;
    localparam int MAX_CASES  = 10;

    logic        clk_logic_w = 1'b0;
    logic        arst;
    logic        a2_phi1_i;
    logic        a2_q3_i;
    logic        a2_reset_n_i;
    logic        report_ready_i;
    logic        report_valid_o;
    edge_count_t report_phi1_o;
    edge_count_t report_q3_o;
    logic        report_overrun_o;
    logic [1:0]  led_o;
    logic        system_reset_n_o;

    logic [15:0] case_mem [0:4*MAX_CASES];
    int          half_1;     // Phi1 half period, 0 holds it low
    int          half_2;     // Q3 half period
    int          glitch_on;
    int          bus_cyc;
    int          err_cnt;
    int          check_cnt;
    bit          timed_out;
    bit          hb_seen;
    logic        hb_prev;
    int          hb_cycles;

    always #5 clk_logic_w = ~clk_logic_w;

    a2_clock_monitor #(
        .WINDOW_CYCLES (WINDOW)
    ) u_a2_clock_monitor (
        .clk_logic_w      (clk_logic_w),
        .arst             (arst),
        .a2_phi1_i        (a2_phi1_i),
        .a2_q3_i          (a2_q3_i),
        .a2_reset_n_i     (a2_reset_n_i),
        .report_ready_i   (report_ready_i),
        .report_valid_o   (report_valid_o),
        .report_phi1_o    (report_phi1_o),
        .report_q3_o      (report_q3_o),
        .report_overrun_o (report_overrun_o),
        .led_o            (led_o),
        .system_reset_n_o (system_reset_n_o)
    );

    task automatic check_count(input string name, input edge_count_t got, input edge_count_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
        end
    endtask

    // One clock step, bus clocks follow the current half periods
    task automatic advance_cycle();
        int p1;
        int p2;
        @(posedge clk_logic_w);
        #1;
        bus_cyc++;
        p1 = (half_1 == 0) ? 0 : bus_cyc % (2 * half_1);
        p2 = (half_2 == 0) ? 0 : bus_cyc % (2 * half_2);
        a2_phi1_i = (half_1 != 0) && ((p1 < half_1) || ((glitch_on != 0) &&
                    (p1 == half_1 + half_1 / 2 || p1 == half_1 + half_1 / 2 + 1)));
        a2_q3_i   = (half_2 != 0) && (p2 < half_2);
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!timed_out && report_valid_o !== 1'b1 && n < WAIT_LIMIT) begin
            advance_cycle();
            n++;
        end
        if (!timed_out && report_valid_o !== 1'b1) begin
            $display("Timeout: no report offered within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic wait_system_reset(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (system_reset_n_o !== level && cycles < limit) begin
            advance_cycle();
            cycles++;
        end
        if (system_reset_n_o !== level) begin
            $display("Timeout: system_reset_n_o did not reach %0b in %0d cycles", level, limit);
            timed_out = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic take_report(output edge_count_t phi1, output edge_count_t q3, output logic ovr);
        phi1           = report_phi1_o;
        q3             = report_q3_o;
        ovr            = report_overrun_o;
        report_ready_i = 1'b1;
        advance_cycle();
        report_ready_i = 1'b0;
    endtask

    task automatic accept_report(input int delay, output edge_count_t phi1,
                                 output edge_count_t q3, output logic ovr);
        int i;
        wait_valid();
        for (i = 0; i < delay; i++) begin
            advance_cycle();  // Ready stays low, report is held
        end
        take_report(phi1, q3, ovr);
    endtask

    // Keep ready low while the given number of windows end
    task automatic hold_reports(input int windows, output edge_count_t phi1,
                                output edge_count_t q3, output logic ovr);
        edge_count_t held_1;
        edge_count_t held_2;
        logic        hb;
        int          seen;
        int          n;
        wait_valid();
        held_1 = report_phi1_o;
        held_2 = report_q3_o;
        hb     = led_o[0];
        seen   = 1;
        n      = 0;
        while (!timed_out && seen < windows && n < WAIT_LIMIT) begin
            advance_cycle();
            n++;
            check_flag("report_valid_o", report_valid_o, 1'b1);
            check_count("report_phi1_o", report_phi1_o, held_1);
            check_count("report_q3_o", report_q3_o, held_2);
            if (led_o[0] !== hb) begin
                hb = led_o[0];
                seen++;
            end
        end
        if (!timed_out && seen < windows) begin
            $display("Timeout: held report did not span %0d windows", windows);
            timed_out = 1'b1;
            err_cnt++;
        end
        take_report(phi1, q3, ovr);
    endtask

    task automatic check_report(input edge_count_t phi1, input edge_count_t q3, input logic ovr,
                                input int exp_1, input int exp_2, input logic exp_ovr);
        if (!timed_out) begin
            check_count("report_phi1_o", phi1, edge_count_t'(exp_1));
            check_count("report_q3_o", q3, edge_count_t'(exp_2));
            check_flag("report_overrun_o", ovr, exp_ovr);
            check_flag("led_o[1]", led_o[1], exp_1 != 0);  // Latest window is a steady one
        end
    endtask

    // Heartbeat period
    always @(negedge clk_logic_w) begin
        if (arst) begin
            hb_seen   = 1'b0;
            hb_prev   = 1'b0;
            hb_cycles = 0;
        end else begin
            hb_cycles++;
            if (led_o[0] !== hb_prev) begin
                if (hb_seen && hb_cycles != WINDOW) begin
                    $display("Heartbeat toggled after %0d cycles instead of %0d", hb_cycles, WINDOW);
                    err_cnt++;
                end
                hb_seen   = 1'b1;
                hb_prev   = led_o[0];
                hb_cycles = 0;
            end
        end
    end

    initial begin
        edge_count_t got_1;
        edge_count_t got_2;
        logic        got_ovr;
        int          n_cases;
        int          exp_1;
        int          exp_2;
        int          hold;
        int          k;
        int          r;
        int          cycles;
        arst           = 1'b1;
        a2_phi1_i      = 1'b0;
        a2_q3_i        = 1'b0;
        a2_reset_n_i   = 1'b1;
        report_ready_i = 1'b0;
        half_1         = 0;
        half_2         = 0;
        glitch_on      = 0;
        bus_cyc        = 0;
        err_cnt        = 0;
        check_cnt      = 0;
        timed_out      = 1'b0;
        n_cases        = 0;
        void'($urandom(32'h3881e068));
        $readmemh("test/clock_monitor_cases.txt", case_mem);

        for (k = 0; k < 10; k++) begin
            advance_cycle();
            check_flag("report_valid_o", report_valid_o, 1'b0);
            check_flag("system_reset_n_o", system_reset_n_o, 1'b0);
            check_flag("led_o (any bit)", |led_o, 1'b0);
        end
        arst = 1'b0;
        wait_system_reset(1'b1, `A2_POR_CYCLES + 20, cycles);
        if (!timed_out && cycles < `A2_POR_CYCLES) begin
            $display("system_reset_n_o rose after only %0d cycles", cycles);
            err_cnt++;
        end
        check_flag("report_valid_o", report_valid_o, 1'b0);
        check_flag("led_o (any bit)", |led_o, 1'b0);
        a2_reset_n_i = 1'b0;  // Apple II reset pulls the system reset down
        wait_system_reset(1'b0, 10, cycles);
        a2_reset_n_i = 1'b1;
        wait_system_reset(1'b1, 10, cycles);
        $display("Reset sequence done, errors so far %0d", err_cnt);

        if (!timed_out) begin
            n_cases = case_mem[0];
        end
        for (k = 0; k < n_cases && !timed_out; k++) begin
            half_1    = case_mem[1 + 4 * k];
            half_2    = case_mem[2 + 4 * k];
            glitch_on = case_mem[3 + 4 * k];
            hold      = case_mem[4 + 4 * k];
            exp_1     = (half_1 == 0) ? 0 : WINDOW / (2 * half_1);
            exp_2     = (half_2 == 0) ? 0 : WINDOW / (2 * half_2);
            accept_report($urandom_range(0, 15), got_1, got_2, got_ovr);  // Mixed window
            if (hold > 0) begin
                hold_reports(hold, got_1, got_2, got_ovr);
                check_report(got_1, got_2, got_ovr, exp_1, exp_2, 1'b1);
                accept_report($urandom_range(0, 15), got_1, got_2, got_ovr);
                check_report(got_1, got_2, got_ovr, exp_1, exp_2, 1'b0);
            end else begin
                for (r = 0; r < 3; r++) begin
                    accept_report($urandom_range(0, 15), got_1, got_2, got_ovr);
                    check_report(got_1, got_2, got_ovr, exp_1, exp_2, 1'b0);
                end
            end
            $display("Case %0d: phi1 half %0d, q3 half %0d, glitch %0d, hold %0d, errors so far %0d",
                     k, half_1, half_2, glitch_on, hold, err_cnt);
        end

        $display("Cases run %0d, checks %0d, errors %0d", n_cases, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/a2_clk_pkg.sv
rtl/clk_track_if.sv
rtl/bus_clock_tracker.sv
rtl/activity_reporter.sv
rtl/power_on_reset.sv
rtl/a2_clock_monitor.sv
test/tb_a2_clock_monitor.sv

/* test/clock_monitor_cases.txt */
// Hex words. The first word is the number of cases, then one case per line:
// phi1_half q3_half glitch ready_hold (half periods in clk_logic_w cycles, 0 holds the clock low)
a
5 a 0 0
14 4 1 0
0 5 0 0
19 0 0 0
14 32 1 3
4 7d 0 0
1f4 fa 0 0
32 64 1 0
a a 0 3
0 0 0 0
